// ==== logic/opx_pkg.sv ====
//////////////////////////////
// Operand path package
// Widths, opcode and operand
// select encodings, and the
// pipeline payload structs
//////////////////////////////

`default_nettype none

package opx_pkg;

	//////////////////////////////
	// Widths
	//////////////////////////////

	// Operand and result width
	localparam int data_w = 32;
	// Lower half of an operand, used by the split multiplier
	localparam int half_w = data_w / 2;
	// Register file depth and address width
	localparam int reg_n = 16;
	localparam int reg_aw = 4;
	// Immediate field, sign extended in ID
	localparam int imm_w = 16;

	//////////////////////////////
	// Encodings
	//////////////////////////////

	// Execute opcodes, MUL gives the low word of the product
	typedef enum logic [2:0] {
		ADD,
		SUB,
		AND,
		OR,
		XOR,
		MUL
	} opcode_e;

	// Operand source, SEL_IMM only valid for operand B
	typedef enum logic [1:0] {
		SEL_RF      = 2'd0,
		SEL_IMM     = 2'd1,
		SEL_EX_FORW = 2'd2,
		SEL_WB_FORW = 2'd3
	} sel_e;

	//////////////////////////////
	// Payload structs
	//////////////////////////////

	// Instruction as presented to ID, 33 bits
	typedef struct packed {
		logic              valid;
		opcode_e           op;
		logic [reg_aw-1:0] rd;
		logic [reg_aw-1:0] ra;
		logic [reg_aw-1:0] rb;
		logic              use_imm;
		logic [imm_w-1:0]  imm;
	} instr_t;

	// Control carried through EX, 8 bits
	typedef struct packed {
		logic              valid;
		opcode_e           op;
		logic [reg_aw-1:0] rd;
	} ex_ctrl_t;

	// Writeback entry, 37 bits
	typedef struct packed {
		logic              valid;
		logic [reg_aw-1:0] rd;
		logic [data_w-1:0] data;
	} wb_t;

endpackage

`default_nettype wire

// ==== logic/reg_file.sv ====
//////////////////////////////
// Register file
// 16 x 32, two async reads,
// one sync write, r0 is zero
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  wire                            clk,
	input  wire                            rst,
	input  wire [opx_pkg::reg_aw-1:0]      raddr_a,
	input  wire [opx_pkg::reg_aw-1:0]      raddr_b,
	input  wire opx_pkg::wb_t              wb,
	output logic [opx_pkg::data_w-1:0]     rdata_a,
	output logic [opx_pkg::data_w-1:0]     rdata_b
);

	// Register storage
	logic [opx_pkg::data_w-1:0] regs [opx_pkg::reg_n];

	// Write port, fed straight from the WB register
	// Cleared on reset so reads never return X
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < opx_pkg::reg_n; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.valid && (wb.rd != '0)) begin
			regs[wb.rd] <= wb.data;
		end
	end

	// Read ports
	// r0 forced to zero whatever the array holds
	assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
	assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

	//////////////////////////////
	// Checks
	//////////////////////////////

	// Known address in, known data out once reset has cleared the array
	a_rdata_known: assert property (@(posedge clk) disable iff (rst)
		!$isunknown({raddr_a, raddr_b}) |-> !$isunknown({rdata_a, rdata_b}))
		else $error("reg_file: X on read port");

	// A write lands and is visible on the next cycle
	a_write_visible: assert property (@(posedge clk) disable iff (rst)
		(wb.valid && (wb.rd != '0) && (raddr_a == wb.rd)) ##1 $stable(raddr_a)
		|-> (rdata_a == $past(wb.data)))
		else $error("reg_file: written value not read back");

endmodule

`default_nettype wire

// ==== logic/forward_ctrl.sv ====
//////////////////////////////
// Forwarding control
// Tracks EX and WB targets and
// picks each operand source
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module forward_ctrl (
	input  wire                 clk,
	input  wire                 rst,
	input  wire                 id_freeze,
	input  wire                 ex_freeze,
	input  wire opx_pkg::instr_t issue,
	input  wire opx_pkg::wb_t    wb,
	output opx_pkg::sel_e        sel_a,
	output opx_pkg::sel_e        sel_b
);

	// Local copy of the EX destination
	logic                       ex_vld;
	logic [opx_pkg::reg_aw-1:0] ex_rd;

	// Same update rule as the EX control register
	// bubble when only ID is frozen, hold when EX is frozen
	always_ff @(posedge clk) begin
		if (rst) begin
			ex_vld <= 1'b0;
		end else if (!ex_freeze) begin
			if (id_freeze) begin
				ex_vld <= 1'b0;
			end else begin
				ex_vld <= issue.valid;
				ex_rd  <= issue.rd;
			end
		end
	end

	// Youngest producer wins, so EX is checked before WB
	// r0 never forwards, it always reads zero from the file
	function automatic opx_pkg::sel_e fwd_src(input logic [opx_pkg::reg_aw-1:0] src);
		if (src == '0)
			return opx_pkg::SEL_RF;
		else if (ex_vld && (ex_rd == src))
			return opx_pkg::SEL_EX_FORW;
		else if (wb.valid && (wb.rd == src))
			return opx_pkg::SEL_WB_FORW;
		else
			return opx_pkg::SEL_RF;
	endfunction

	always_comb begin
		sel_a = fwd_src(issue.ra);
		// Immediate overrides any register match on B
		if (issue.use_imm)
			sel_b = opx_pkg::SEL_IMM;
		else
			sel_b = fwd_src(issue.rb);
	end

	// Operand A has no immediate path
	a_sel_a_no_imm: assert property (@(posedge clk) disable iff (rst)
		sel_a != opx_pkg::SEL_IMM)
		else $error("forward_ctrl: SEL_IMM on operand A");

endmodule

`default_nettype wire

// ==== logic/operand_muxes.sv ====
//////////////////////////////
// Operand muxes
// Forwarding muxes plus the
// freeze aware operand regs
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module operand_muxes (
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          id_freeze,
	input  wire                          ex_freeze,
	input  wire [opx_pkg::data_w-1:0]    rf_dataa,
	input  wire [opx_pkg::data_w-1:0]    rf_datab,
	input  wire [opx_pkg::data_w-1:0]    ex_forw,
	input  wire [opx_pkg::data_w-1:0]    wb_forw,
	input  wire [opx_pkg::data_w-1:0]    simm,
	input  wire opx_pkg::sel_e           sel_a,
	input  wire opx_pkg::sel_e           sel_b,
	output logic [opx_pkg::data_w-1:0]   operand_a,
	output logic [opx_pkg::data_w-1:0]   operand_b
);

	// Index 0 is operand A, index 1 is operand B
	logic [opx_pkg::data_w-1:0] muxed [2];
	logic [opx_pkg::data_w-1:0] opnd  [2];
	logic [1:0]                 saved;

	//////////////////////////////
	// Forwarding muxes
	//////////////////////////////

	// Unknown or RF select falls back to the register file
	function automatic logic [opx_pkg::data_w-1:0] pick(
		input opx_pkg::sel_e              sel,
		input logic [opx_pkg::data_w-1:0] rf,
		input logic [opx_pkg::data_w-1:0] imm
	);
		case (sel)
			opx_pkg::SEL_IMM:     return imm;
			opx_pkg::SEL_EX_FORW: return ex_forw;
			opx_pkg::SEL_WB_FORW: return wb_forw;
			default:              return rf;
		endcase
	endfunction

	// A has no immediate, so its IMM leg repeats the RF data
	always_comb begin
		muxed[0] = pick(sel_a, rf_dataa, rf_dataa);
		muxed[1] = pick(sel_b, rf_datab, simm);
	end

	//////////////////////////////
	// Operand registers
	//////////////////////////////

	// EX running, ID frozen: take the first capture and mark it saved
	// EX running, nothing saved: normal load every cycle
	// Saved value is held until both stages run again
	always_ff @(posedge clk) begin
		for (int i = 0; i < 2; i++) begin
			if (rst) begin
				opnd[i]  <= '0;
				saved[i] <= 1'b0;
			end else if (!ex_freeze && id_freeze && !saved[i]) begin
				opnd[i]  <= muxed[i];
				saved[i] <= 1'b1;
			end else if (!ex_freeze && !saved[i]) begin
				opnd[i]  <= muxed[i];
			end else if (!ex_freeze && !id_freeze) begin
				saved[i] <= 1'b0;
			end
		end
	end

	assign operand_a = opnd[0];
	assign operand_b = opnd[1];

	//////////////////////////////
	// Checks
	//////////////////////////////

	// A forwarded EX result is what A holds on the next cycle
	a_fwd_ex_a: assert property (@(posedge clk) disable iff (rst)
		(!ex_freeze && !saved[0] && (sel_a == opx_pkg::SEL_EX_FORW))
		|=> (operand_a == $past(ex_forw)))
		else $error("operand_muxes: A missed the EX forward");

	// Immediate select lands the sign extended immediate in B
	a_imm_b: assert property (@(posedge clk) disable iff (rst)
		(!ex_freeze && !saved[1] && (sel_b == opx_pkg::SEL_IMM))
		|=> (operand_b == $past(simm)))
		else $error("operand_muxes: B missed the immediate");

	// A saved capture is never overwritten
	a_saved_hold: assert property (@(posedge clk) disable iff (rst)
		(saved != 2'b00) |=> ($stable(operand_a) || !$past(saved[0]))
		&& ($stable(operand_b) || !$past(saved[1])))
		else $error("operand_muxes: saved operand changed");

endmodule

`default_nettype wire

// ==== logic/freeze_ctrl.sv ====
//////////////////////////////
// Freeze control
// Builds ID and EX freezes from
// stall, hold and MUL phase
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module freeze_ctrl (
	input  wire  clk,
	input  wire  rst,
	input  wire  mem_stall,
	input  wire  dec_hold,
	input  wire  ex_is_mul,
	output logic id_freeze,
	output logic ex_freeze
);

	// MUL_BUSY marks the second EX cycle of a multiply
	typedef enum logic {
		IDLE,
		MUL_BUSY
	} mul_state_e;

	mul_state_e state;
	logic       mul_first;

	// First cycle of a MUL in EX holds both stages
	assign mul_first = ex_is_mul && (state == IDLE);

	assign ex_freeze = mem_stall || mul_first;
	// ID can never run ahead of a frozen EX
	assign id_freeze = ex_freeze || dec_hold;

	// Phase only advances when memory is not stalling
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
		end else if (!mem_stall) begin
			case (state)
				IDLE:     if (ex_is_mul) state <= MUL_BUSY;
				MUL_BUSY: state <= IDLE;
				default:  state <= IDLE;
			endcase
		end
	end

	a_ex_implies_id: assert property (@(posedge clk) disable iff (rst)
		ex_freeze |-> id_freeze)
		else $error("freeze_ctrl: EX frozen while ID runs");

endmodule

`default_nettype wire

// ==== logic/exec_unit.sv ====
//////////////////////////////
// Execute unit
// EX control, ALU, two cycle
// multiply and WB register
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module exec_unit (
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          id_freeze,
	input  wire                          ex_freeze,
	input  wire opx_pkg::instr_t         issue,
	input  wire [opx_pkg::data_w-1:0]    operand_a,
	input  wire [opx_pkg::data_w-1:0]    operand_b,
	output logic [opx_pkg::data_w-1:0]   ex_forw,
	output logic                         ex_is_mul,
	output opx_pkg::wb_t                 wb
);

	localparam int hw = opx_pkg::half_w;

	opx_pkg::ex_ctrl_t          ex_ctrl;
	// Partial products kept between the two MUL cycles
	logic [opx_pkg::data_w-1:0] mul_lo;
	logic [hw-1:0]              mul_cross;

	//////////////////////////////
	// EX control register
	//////////////////////////////

	// Bubble when only ID is frozen, hold while EX is frozen
	always_ff @(posedge clk) begin
		if (rst) begin
			ex_ctrl.valid <= 1'b0;
		end else if (!ex_freeze) begin
			if (id_freeze) begin
				ex_ctrl.valid <= 1'b0;
			end else begin
				ex_ctrl.valid <= issue.valid;
				ex_ctrl.op    <= issue.op;
				ex_ctrl.rd    <= issue.rd;
			end
		end
	end

	assign ex_is_mul = ex_ctrl.valid && (ex_ctrl.op == opx_pkg::MUL);

	//////////////////////////////
	// Multiply
	//////////////////////////////

	// First cycle: low x low, and the cross terms folded to one half
	// High x high only touches bits above the low word, so it is dropped
	always_ff @(posedge clk) begin
		if (ex_is_mul) begin
			mul_lo    <= operand_a[hw-1:0] * operand_b[hw-1:0];
			mul_cross <= operand_a[hw-1:0] * operand_b[opx_pkg::data_w-1:hw]
				+ operand_a[opx_pkg::data_w-1:hw] * operand_b[hw-1:0];
		end
	end

	//////////////////////////////
	// ALU
	//////////////////////////////

	// MUL output is only meaningful in its second EX cycle
	always_comb begin
		case (ex_ctrl.op)
			opx_pkg::ADD: ex_forw = operand_a + operand_b;
			opx_pkg::SUB: ex_forw = operand_a - operand_b;
			opx_pkg::AND: ex_forw = operand_a & operand_b;
			opx_pkg::OR:  ex_forw = operand_a | operand_b;
			opx_pkg::XOR: ex_forw = operand_a ^ operand_b;
			opx_pkg::MUL: ex_forw = mul_lo + {mul_cross, {hw{1'b0}}};
			default:      ex_forw = '0;
		endcase
	end

	// WB register, invalid entry whenever EX is frozen
	always_ff @(posedge clk) begin
		if (rst) begin
			wb.valid <= 1'b0;
		end else if (!ex_freeze) begin
			wb.valid <= ex_ctrl.valid;
			wb.rd    <= ex_ctrl.rd;
			wb.data  <= ex_forw;
		end else begin
			wb.valid <= 1'b0;
		end
	end

	a_no_result_in_reset: assert property (@(posedge clk)
		rst |=> !wb.valid)
		else $error("exec_unit: valid result during reset");

endmodule

`default_nettype wire

// ==== logic/opx_core.sv ====
//////////////////////////////
// Operand path top level
// ID, EX and WB stages with
// forwarding and freezes
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module opx_core (
	input  wire                  clk,
	input  wire                  rst,
	input  wire opx_pkg::instr_t issue,
	input  wire                  dec_hold,
	input  wire                  mem_stall,
	output opx_pkg::wb_t         result
);

	// Register file reads
	logic [opx_pkg::data_w-1:0] rf_dataa;
	logic [opx_pkg::data_w-1:0] rf_datab;
	// Forwarding selects
	opx_pkg::sel_e              sel_a;
	opx_pkg::sel_e              sel_b;
	// Operands into EX
	logic [opx_pkg::data_w-1:0] operand_a;
	logic [opx_pkg::data_w-1:0] operand_b;
	// Forward paths and immediate
	logic [opx_pkg::data_w-1:0] ex_forw;
	logic [opx_pkg::data_w-1:0] wb_forw;
	logic [opx_pkg::data_w-1:0] simm;
	// Freeze levels
	logic                       id_freeze;
	logic                       ex_freeze;
	logic                       ex_is_mul;

	// Sign extend the immediate in ID
	assign simm = {{(opx_pkg::data_w - opx_pkg::imm_w){issue.imm[opx_pkg::imm_w-1]}},
		issue.imm};

	// WB data doubles as the second forward path
	assign wb_forw = result.data;

	//////////////////////////////
	// Stages
	//////////////////////////////

	reg_file u_reg_file (
		.clk     (clk),
		.rst     (rst),
		.raddr_a (issue.ra),
		.raddr_b (issue.rb),
		.wb      (result),
		.rdata_a (rf_dataa),
		.rdata_b (rf_datab)
	);

	forward_ctrl u_forward_ctrl (
		.clk       (clk),
		.rst       (rst),
		.id_freeze (id_freeze),
		.ex_freeze (ex_freeze),
		.issue     (issue),
		.wb        (result),
		.sel_a     (sel_a),
		.sel_b     (sel_b)
	);

	operand_muxes u_operand_muxes (
		.clk       (clk),
		.rst       (rst),
		.id_freeze (id_freeze),
		.ex_freeze (ex_freeze),
		.rf_dataa  (rf_dataa),
		.rf_datab  (rf_datab),
		.ex_forw   (ex_forw),
		.wb_forw   (wb_forw),
		.simm      (simm),
		.sel_a     (sel_a),
		.sel_b     (sel_b),
		.operand_a (operand_a),
		.operand_b (operand_b)
	);

	freeze_ctrl u_freeze_ctrl (
		.clk       (clk),
		.rst       (rst),
		.mem_stall (mem_stall),
		.dec_hold  (dec_hold),
		.ex_is_mul (ex_is_mul),
		.id_freeze (id_freeze),
		.ex_freeze (ex_freeze)
	);

	exec_unit u_exec_unit (
		.clk       (clk),
		.rst       (rst),
		.id_freeze (id_freeze),
		.ex_freeze (ex_freeze),
		.issue     (issue),
		.operand_a (operand_a),
		.operand_b (operand_b),
		.ex_forw   (ex_forw),
		.ex_is_mul (ex_is_mul),
		.wb        (result)
	);

endmodule

`default_nettype wire

// ==== bench/opx_ref_model.svh ====
//////////////////////////////
// Reference model
// In order register array and
// queue of expected results
//////////////////////////////

`ifndef OPX_REF_MODEL_SVH
`define OPX_REF_MODEL_SVH

// Architectural registers, updated at issue in program order
logic [opx_pkg::data_w-1:0] model_regs [opx_pkg::reg_n];
// Results still owed by the DUT, oldest first
opx_pkg::wb_t               exp_q [$];
// Static view of the queue head for the result assertion
opx_pkg::wb_t               exp_head;
logic                       exp_avail;

function automatic void refresh_head();
	exp_avail = (exp_q.size() != 0);
	exp_head  = exp_avail ? exp_q[0] : '0;
endfunction

task automatic model_reset();
	for (int i = 0; i < opx_pkg::reg_n; i++) begin
		model_regs[i] = '0;
	end
	exp_q.delete();
	refresh_head();
endtask

// r0 always reads as zero
function automatic logic [opx_pkg::data_w-1:0] read_reg(input logic [opx_pkg::reg_aw-1:0] r);
	return (r == '0) ? '0 : model_regs[r];
endfunction

// Execute one accepted instruction and queue its result
task automatic model_issue(input opx_pkg::instr_t ins);
	logic [opx_pkg::data_w-1:0] a;
	logic [opx_pkg::data_w-1:0] b;
	logic [opx_pkg::data_w-1:0] res;
	opx_pkg::wb_t               entry;
	a = read_reg(ins.ra);
	// Immediate is sign extended to the full operand width
	b = ins.use_imm ? 32'($signed(ins.imm)) : read_reg(ins.rb);
	case (ins.op)
		opx_pkg::ADD: res = a + b;
		opx_pkg::SUB: res = a - b;
		opx_pkg::AND: res = a & b;
		opx_pkg::OR:  res = a | b;
		opx_pkg::XOR: res = a ^ b;
		// Low word of the product
		opx_pkg::MUL: res = a * b;
		default:      res = '0;
	endcase
	if (ins.rd != '0) begin
		model_regs[ins.rd] = res;
	end
	entry.valid = 1'b1;
	entry.rd    = ins.rd;
	entry.data  = res;
	exp_q.push_back(entry);
	refresh_head();
endtask

task automatic model_pop();
	void'(exp_q.pop_front());
	refresh_head();
endtask

`endif

// ==== bench/opx_core_tb.sv ====
//////////////////////////////
// Operand path testbench
// Dependent random streams with
// stalls, holds and multiplies
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module opx_core_tb;

	// Instruction count over all phases sets the timeout
	localparam int n_total     = 185;
	localparam int cycle_limit = 4 * n_total + 100;

	logic            clk;
	logic            rst;
	opx_pkg::instr_t issue;
	logic            dec_hold;
	logic            mem_stall;
	opx_pkg::wb_t    result;

	int   value_errs;
	int   other_errs;
	int   n_issued;
	int   n_results;
	int   cycles;
	// Stimulus state
	logic mul_pending;
	logic stall_en;
	logic hold_en;
	int   stall_left;
	int   hold_left;

	`include "opx_ref_model.svh"

	opx_core dut0 (
		.clk       (clk),
		.rst       (rst),
		.issue     (issue),
		.dec_hold  (dec_hold),
		.mem_stall (mem_stall),
		.result    (result)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	//////////////////////////////
	// Result checking
	//////////////////////////////

	// Every valid result sampled mid cycle must match the oldest expected one
	a_result_match: assert property (@(negedge clk) disable iff (rst)
		result.valid |-> (exp_avail && (result == exp_head)))
		else begin
			if (!$sampled(exp_avail)) begin
				other_errs++;
				$display("Result for r%0d at %0t with no instruction pending",
					$sampled(result.rd), $time);
			end else begin
				value_errs++;
				$display("** Error %0t: result expected %h got %h",
					$time, $sampled(exp_head), $sampled(result));
			end
		end

	always @(negedge clk) begin
		if (!rst && result.valid) begin
			n_results++;
			if (exp_avail) begin
				model_pop();
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("Timeout after %0d cycles, %0d results still pending",
				cycles, exp_q.size());
			$display("Errors: %0d value, %0d other", value_errs, other_errs);
			$display("*** FAILED ***");
			$finish;
		end
	end

	//////////////////////////////
	// Stimulus helpers
	//////////////////////////////

	function automatic opx_pkg::instr_t make_instr(
		input opx_pkg::opcode_e           op,
		input int                         rd,
		input int                         ra,
		input int                         rb,
		input logic                       use_imm,
		input logic [opx_pkg::imm_w-1:0]  imm
	);
		opx_pkg::instr_t ins;
		ins.valid   = 1'b1;
		ins.op      = op;
		ins.rd      = rd[opx_pkg::reg_aw-1:0];
		ins.ra      = ra[opx_pkg::reg_aw-1:0];
		ins.rb      = rb[opx_pkg::reg_aw-1:0];
		ins.use_imm = use_imm;
		ins.imm     = imm;
		return ins;
	endfunction

	function automatic opx_pkg::opcode_e rand_op(input logic with_mul);
		int n;
		n = with_mul ? 6 : 5;
		return opx_pkg::opcode_e'($urandom % n);
	endfunction

	// Operand A always depends on the previous destination
	function automatic opx_pkg::instr_t rand_instr(input int prev, input logic with_mul);
		return make_instr(rand_op(with_mul), 1 + $urandom % 15, prev, $urandom % 16,
			($urandom % 4) == 0, 16'($urandom));
	endfunction

	// One cycle of stall and hold pulses with random start and length
	task automatic drive_stalls();
		if (stall_en && (stall_left == 0) && (($urandom % 6) == 0))
			stall_left = 1 + $urandom % 4;
		if (hold_en && (hold_left == 0) && (($urandom % 6) == 0))
			hold_left = 1 + $urandom % 4;
		mem_stall = (stall_left != 0);
		dec_hold  = (hold_left != 0);
		if (stall_left != 0)
			stall_left--;
		if (hold_left != 0)
			hold_left--;
	endtask

	// Hold the instruction until an edge with ID free takes it
	// ID is busy on a stall, a hold, or the first frozen cycle of a MUL
	task automatic send(input opx_pkg::instr_t ins);
		logic accepted;
		accepted = 1'b0;
		@(negedge clk);
		issue = ins;
		while (!accepted) begin
			drive_stalls();
			@(posedge clk);
			accepted = !mem_stall && !dec_hold && !mul_pending;
			// MUL phase only advances when memory is not stalling
			if (!mem_stall)
				mul_pending = 1'b0;
			if (accepted) begin
				model_issue(ins);
				n_issued++;
				if (ins.op == opx_pkg::MUL)
					mul_pending = 1'b1;
			end else begin
				@(negedge clk);
			end
		end
	endtask

	// Idle input until every queued result is back
	task automatic drain();
		@(negedge clk);
		issue      = '0;
		mem_stall  = 1'b0;
		dec_hold   = 1'b0;
		stall_en   = 1'b0;
		hold_en    = 1'b0;
		stall_left = 0;
		hold_left  = 0;
		do @(posedge clk); while (exp_avail);
		mul_pending = 1'b0;
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial begin
		int prev;
		int target;
		void'($urandom(32'h07f9_f610));
		rst = 1'b1;
		issue = '0;
		dec_hold = 1'b0;
		mem_stall = 1'b0;
		{value_errs, other_errs, n_issued, n_results, cycles} = '0;
		{mul_pending, stall_en, hold_en} = '0;
		stall_left = 0;
		hold_left = 0;
		model_reset();
		repeat (10) @(negedge clk);
		rst = 1'b0;

		// Seed every register from an immediate
		for (int r = 1; r < 16; r++)
			send(make_instr(opx_pkg::ADD, r, 0, 0, 1'b1, 16'($urandom)));

		// Back to back dependence alternating between A and B
		prev = 1;
		for (int k = 0; k < 12; k++) begin
			target = 1 + $urandom % 15;
			if (k % 2)
				send(make_instr(rand_op(1'b0), target, $urandom % 16, prev, 1'b0, '0));
			else
				send(make_instr(rand_op(1'b0), target, prev, $urandom % 16, 1'b0, '0));
			prev = target;
		end

		// Dependence at distance two, three and four
		for (int k = 0; k < 6; k++) begin
			target = 1 + $urandom % 15;
			send(make_instr(rand_op(1'b0), target, 1 + $urandom % 15, 1 + $urandom % 15,
				1'b0, '0));
			for (int f = 1; f < 2 + k % 3; f++)
				send(make_instr(opx_pkg::ADD, target % 15 + 1, $urandom % 16, $urandom % 16,
					1'b0, '0));
			send(make_instr(rand_op(1'b0), 1 + $urandom % 15, target,
				(k % 2) ? target : $urandom % 16, 1'b0, '0));
		end
		// A write to r0 is dropped and the next read still sees zero
		send(make_instr(opx_pkg::ADD, 0, 1, 0, 1'b1, 16'h1234));
		send(make_instr(opx_pkg::OR, 5, 0, 0, 1'b0, '0));

		// Immediates with every other one negative
		for (int k = 0; k < 10; k++)
			send(make_instr(rand_op(1'b0), 1 + $urandom % 15, prev, 0, 1'b1,
				16'($urandom) | ((k % 2) ? 16'h0000 : 16'h8000)));
		drain();

		// Dependent stream under memory stalls
		stall_en = 1'b1;
		for (int k = 0; k < 40; k++) begin
			send(rand_instr(prev, 1'b0));
			prev = issue.rd;
		end
		drain();

		// Dependent stream under decode holds
		hold_en = 1'b1;
		for (int k = 0; k < 40; k++) begin
			send(rand_instr(prev, 1'b0));
			prev = issue.rd;
		end
		drain();

		// MUL with its consumer right behind
		for (int k = 0; k < 6; k++) begin
			target = 1 + $urandom % 15;
			send(make_instr(opx_pkg::MUL, target, 1 + $urandom % 15, 1 + $urandom % 15,
				1'b0, '0));
			send(make_instr(rand_op(1'b0), 1 + $urandom % 15, target, $urandom % 16,
				1'b0, '0));
		end
		drain();

		// Everything at once
		stall_en = 1'b1;
		hold_en = 1'b1;
		for (int k = 0; k < 30; k++) begin
			send(rand_instr(prev, 1'b1));
			prev = issue.rd;
		end
		drain();

		// Idle window catches stray or duplicated results
		repeat (8) @(posedge clk);
		a_result_count: assert (n_results == n_issued)
			else begin
				other_errs++;
				$display("Issued %0d instructions but saw %0d results", n_issued, n_results);
			end
		$display("Errors: %0d value, %0d other, %0d results for %0d issued",
			value_errs, other_errs, n_results, n_issued);
		if ((value_errs == 0) && (other_errs == 0))
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== opx_core.f ====
+incdir+bench
logic/opx_pkg.sv
logic/reg_file.sv
logic/forward_ctrl.sv
logic/operand_muxes.sv
logic/freeze_ctrl.sv
logic/exec_unit.sv
logic/opx_core.sv
bench/opx_core_tb.sv
